/* build.f */
verilog/permutePkg.sv
verilog/syncFifo.sv
verilog/botPermuter.sv
verilog/subsetChecker.sv
verilog/freeBitCounter.sv
verilog/pcoeffAccumulator.sv
verilog/aggregatingPermutePipeline.sv
test/aggregatingPermutePipelineTb.sv

/* run.sh */
#!/bin/sh
verilator --binary --timing -Wno-fatal -f build.f \
    --top-module aggregatingPermutePipelineTb -o simv > build.log 2>&1 \
    && ./obj_dir/simv > sim.log 2>&1 \
    && grep -q "^STATUS: PASS$" sim.log \
    && echo "simulation passed" || { echo "simulation failed, see sim.log"; exit 1; }

/* test/aggregatingPermutePipelineTb.sv */
module aggregatingPermutePipelineTb;
    import permutePkg::*;

    localparam int SINGLE_BOTS = 40;
    localparam int RANDOM_BATCHES = 30;
    localparam int MAX_BATCH_BOTS = 8;
    localparam int ZERO_WRITES = 64;
    localparam int BURST_BOTS = 48;
    localparam int STALL_LIMIT = 16;
    // dropped writes can double a batch in the worst case
    localparam int WRITE_BUDGET = SINGLE_BOTS + RANDOM_BATCHES * MAX_BATCH_BOTS * 2
        + ZERO_WRITES + BURST_BOTS;
    localparam int TIMEOUT_CYCLES = WRITE_BUDGET * 8 + 1000;

    logic clk;
    logic rst;
    botT top;
    botT bot;
    logic writeData;
    permuteMaskT validBotPermutes;
    logic batchDone;
    logic grabResults;
    logic slowDownInput;
    logic resultsAvailable;
    logic [SUM_WIDTH-1:0] pcoeffSum;
    logic [COUNT_WIDTH-1:0] pcoeffCount;

    logic [31:0] lfsrState = 32'h7639_0697;
    int errors = 0;
    int checks = 0;
    int modelSum = 0;
    int modelCount = 0;
    int expSum[$];
    int expCount[$];
    bit grabOn = 1'b1;
    bit sawSlowDown = 1'b0;
    // indexed by mask bit so that bit 5 is ABC
    string permNames[PERMUTE_COUNT] = '{"CBA", "CAB", "BCA", "BAC", "ACB", "ABC"};

    aggregatingPermutePipeline dut0 (
        .clk(clk),
        .rst(rst),
        .top(top),
        .bot(bot),
        .writeData(writeData),
        .validBotPermutes(validBotPermutes),
        .batchDone(batchDone),
        .slowDownInput(slowDownInput),
        .grabResults(grabResults),
        .resultsAvailable(resultsAvailable),
        .pcoeffSum(pcoeffSum),
        .pcoeffCount(pcoeffCount)
    );

    always #4 clk = ~clk;

    // taps 32, 22, 2, 1
    function automatic logic [31:0] stepLfsr(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic logic [127:0] randBits(input int n);
        logic [127:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsrState = stepLfsr(lfsrState);
            v = {v[126:0], lfsrState[0]};
        end
        return v;
    endfunction

    // chunk (o6, o5, o4) of the result comes from the chunk where X=o6, Y=o5, Z=o4
    function automatic botT permuteModel(input botT b, input int p);
        string order;
        botT res;
        int src;
        int varIdx;
        order = permNames[p];
        res = '0;
        for (int o = 0; o < 8; o++) begin
            src = 0;
            for (int k = 0; k < 3; k++) begin
                varIdx = int'(order[k]) - 65;
                if (o[2-k]) begin
                    src += 1 << (2 - varIdx);
                end
            end
            res[o*16 +: 16] = b[src*16 +: 16];
        end
        return res;
    endfunction

    function automatic int countFree(input botT b);
        botT left;
        int n;
        left = top & ~b;
        n = 0;
        for (int i = 0; i < BOT_WIDTH; i++) begin
            n += left[i];
        end
        return n;
    endfunction

    // mix of dense, sparse, inside-top and empty bots
    function automatic botT pickBot();
        logic [1:0] sel;
        sel = randBits(2);
        case (sel)
            2'd0: return randBits(128);
            2'd1: return randBits(128) & randBits(128) & randBits(128) & randBits(128);
            2'd2: return randBits(128) & randBits(128) & top;
            default: return '0;
        endcase
    endfunction

    task automatic checkValue(input logic [31:0] got, input logic [31:0] exp,
                              input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("error at time %0t: %s is %0d, expected %0d", $time, what, got, exp);
        end
    endtask

    task automatic modelWrite(input botT b, input permuteMaskT m, input logic done);
        botT pb;
        for (int p = PERMUTE_COUNT - 1; p >= 0; p--) begin
            if (m[p]) begin
                pb = permuteModel(b, p);
                if ((pb & ~top) == '0) begin
                    modelSum += countFree(pb);
                    modelCount++;
                end
            end
        end
        if (done) begin
            expSum.push_back(modelSum);
            expCount.push_back(modelCount);
            modelSum = 0;
            modelCount = 0;
        end
    endtask

    // pop the head at random and check it on the way out
    task automatic serviceResults();
        grabResults = 1'b0;
        if (grabOn && resultsAvailable && randBits(1) == 1) begin
            if (expSum.size() == 0) begin
                errors++;
                $display("a result appeared at time %0t while no batch was pending", $time);
            end else begin
                checkValue(pcoeffSum, expSum.pop_front(), "batch sum");
                checkValue(pcoeffCount, expCount.pop_front(), "batch count");
            end
            grabResults = 1'b1;
        end
    endtask

    task automatic nextCycle();
        @(posedge clk);
        #1;
        writeData = 1'b0;
        serviceResults();
    endtask

    task automatic writeBot(input botT b, input permuteMaskT m, input logic done);
        int stall;
        stall = 0;
        nextCycle();
        while (slowDownInput) begin
            sawSlowDown = 1'b1;
            stall++;
            // the results reader wakes up once the source is stuck
            if (stall > STALL_LIMIT) begin
                grabOn = 1'b1;
            end
            nextCycle();
        end
        bot = b;
        validBotPermutes = m;
        batchDone = done;
        writeData = 1'b1;
        modelWrite(b, m, done);
    endtask

    task automatic drainResults();
        grabOn = 1'b1;
        while (expSum.size() > 0) begin
            nextCycle();
        end
        repeat (8) nextCycle();
        checkValue(resultsAvailable, 0, "resultsAvailable after drain");
    endtask

    initial begin
        repeat (TIMEOUT_CYCLES) @(posedge clk);
        $display("watchdog expired after %0d cycles, the run hung", TIMEOUT_CYCLES);
        $display("STATUS: FAIL");
        $finish;
    end

    initial begin
        int len;
        permuteMaskT m;
        clk = 1'b0;
        rst = 1'b1;
        writeData = 1'b0;
        grabResults = 1'b0;
        bot = '0;
        validBotPermutes = '0;
        batchDone = 1'b0;
        // dense top so that sparse bots often fit inside
        top = randBits(128) | randBits(128);
        repeat (4) @(posedge clk);
        #1;
        rst = 1'b0;
        checkValue(resultsAvailable, 0, "resultsAvailable after reset");
        checkValue(slowDownInput, 0, "slowDownInput after reset");

        // identity permutation with one bot per batch
        for (int i = 0; i < SINGLE_BOTS; i++) begin
            if (i % 2 == 0) begin
                writeBot(randBits(128) & top, 6'b100000, 1'b1);
            end else begin
                writeBot(pickBot(), 6'b100000, 1'b1);
            end
        end
        drainResults();

        // random masks and batch lengths with dropped writes mixed in
        for (int n = 0; n < RANDOM_BATCHES; n++) begin
            len = 1 + int'(randBits(3));
            for (int j = 0; j < len; j++) begin
                if (randBits(3) == 0) begin
                    writeBot(randBits(128), '0, 1'b0);
                end
                writeBot(pickBot(), randBits(6), j == len - 1);
            end
        end
        drainResults();

        // empty masks without batch end must vanish
        // accepted ones would be enough to fill the input FIFO
        sawSlowDown = 1'b0;
        for (int i = 0; i < ZERO_WRITES - 4; i++) begin
            writeBot(randBits(128), '0, 1'b0);
        end
        repeat (10) nextCycle();
        checkValue(resultsAvailable, 0, "resultsAvailable after dropped writes");
        checkValue(sawSlowDown, 0, "slowDownInput during dropped writes");
        writeBot(randBits(128), '0, 1'b1);
        writeBot(randBits(128) & top, 6'b111111, 1'b0);
        writeBot(randBits(128), '0, 1'b0);
        writeBot(randBits(128), '0, 1'b1);
        drainResults();

        // burst with the reader parked
        grabOn = 1'b0;
        sawSlowDown = 1'b0;
        for (int i = 0; i < BURST_BOTS; i++) begin
            m = randBits(6);
            if (m == '0) begin
                m = 6'b000001;
            end
            writeBot(pickBot(), m, 1'b1);
        end
        checkValue(sawSlowDown, 1, "slowDownInput raised during burst");
        drainResults();

        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

/* verilog/aggregatingPermutePipeline.sv */
module aggregatingPermutePipeline (
    input logic clk,
    input logic rst,
    input permutePkg::botT top,
    input permutePkg::botT bot,
    input logic writeData,
    input permutePkg::permuteMaskT validBotPermutes,
    input logic batchDone,
    output logic slowDownInput,
    input logic grabResults,
    output logic resultsAvailable,
    output logic [permutePkg::SUM_WIDTH-1:0] pcoeffSum,
    output logic [permutePkg::COUNT_WIDTH-1:0] pcoeffCount
);
    import permutePkg::*;

    inputEntryT inputWrite;
    inputEntryT inputHead;
    logic inputWriteEnable;
    logic inputEmpty;
    logic [INPUT_FIFO_DEPTH_LOG2:0] inputUsedw;

    logic popBot;
    logic permIdle;
    logic permValid;
    logic permLast;
    botT permBot;

    logic checkSubset;
    logic checkValid;
    logic checkLast;
    logic [FREE_COUNT_WIDTH-1:0] checkFree;

    logic accValid;
    resultEntryT resultWrite;
    resultEntryT resultHead;
    logic resultsEmpty;
    logic [RESULTS_FIFO_DEPTH_LOG2:0] resultsUsedw;

    // empty masks carry nothing unless they close a batch
    assign inputWriteEnable = writeData && (|validBotPermutes || batchDone);

    always_comb begin
        inputWrite.bot = bot;
        inputWrite.mask = validBotPermutes;
        inputWrite.batchDone = batchDone;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            slowDownInput <= 1'b0;
        end else begin
            slowDownInput <= inputUsedw > SLOW_DOWN_THRESHOLD;
        end
    end

    // hold bots back while the results queue lacks room for in-flight batches
    assign popBot = permIdle && !inputEmpty
        && (resultsUsedw <= (2**RESULTS_FIFO_DEPTH_LOG2) - RESULTS_HEADROOM);

    syncFifo #(.payloadT(inputEntryT), .DEPTH_LOG2(INPUT_FIFO_DEPTH_LOG2)) inputFifo (
        .clk(clk),
        .rst(rst),
        .writeEnable(inputWriteEnable),
        .dataIn(inputWrite),
        .readEnable(popBot),
        .dataOut(inputHead),
        .empty(inputEmpty),
        .usedw(inputUsedw)
    );

    botPermuter permuter0 (
        .clk(clk),
        .rst(rst),
        .load(popBot),
        .botIn(inputHead.bot),
        .maskIn(inputHead.mask),
        .lastIn(inputHead.batchDone),
        .idle(permIdle),
        .outValid(permValid),
        .outLast(permLast),
        .outBot(permBot)
    );

    // both checkers see the same item and stay aligned
    subsetChecker subsetCheck0 (
        .clk(clk),
        .rst(rst),
        .top(top),
        .inValid(permValid),
        .inLast(permLast),
        .inBot(permBot),
        .subsetOut(checkSubset),
        .validOut(checkValid),
        .lastOut(checkLast)
    );

    freeBitCounter freeCount0 (
        .clk(clk),
        .rst(rst),
        .top(top),
        .inBot(permBot),
        .freeCount(checkFree)
    );

    pcoeffAccumulator accumulator0 (
        .clk(clk),
        .rst(rst),
        .itemValid(checkValid),
        .itemSubset(checkSubset),
        .itemLast(checkLast),
        .freeCount(checkFree),
        .resultValid(accValid),
        .resultSum(resultWrite.sum),
        .resultCount(resultWrite.count)
    );

    syncFifo #(.payloadT(resultEntryT), .DEPTH_LOG2(RESULTS_FIFO_DEPTH_LOG2)) resultsFifo (
        .clk(clk),
        .rst(rst),
        .writeEnable(accValid),
        .dataIn(resultWrite),
        .readEnable(grabResults),
        .dataOut(resultHead),
        .empty(resultsEmpty),
        .usedw(resultsUsedw)
    );

    assign resultsAvailable = !resultsEmpty;
    assign pcoeffSum = resultHead.sum;
    assign pcoeffCount = resultHead.count;

endmodule

/* verilog/pcoeffAccumulator.sv */
module pcoeffAccumulator (
    input logic clk,
    input logic rst,
    input logic itemValid,
    input logic itemSubset,
    input logic itemLast,
    input logic [permutePkg::FREE_COUNT_WIDTH-1:0] freeCount,
    output logic resultValid,
    output logic [permutePkg::SUM_WIDTH-1:0] resultSum,
    output logic [permutePkg::COUNT_WIDTH-1:0] resultCount
);
    import permutePkg::*;

    logic [SUM_WIDTH-1:0] sum;
    logic [COUNT_WIDTH-1:0] count;
    logic contributes;
    logic [SUM_WIDTH-1:0] sumNext;
    logic [COUNT_WIDTH-1:0] countNext;

    // only subset items add to the batch
    assign contributes = itemValid && itemSubset;
    assign sumNext = contributes ? sum + SUM_WIDTH'(freeCount) : sum;
    assign countNext = contributes ? count + COUNT_WIDTH'(1) : count;

    always_ff @(posedge clk) begin
        if (rst) begin
            sum <= '0;
            count <= '0;
            resultValid <= 1'b0;
        end else if (itemLast) begin
            // close the batch with the last item included
            sum <= '0;
            count <= '0;
            resultValid <= 1'b1;
        end else begin
            sum <= sumNext;
            count <= countNext;
            resultValid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (itemLast) begin
            resultSum <= sumNext;
            resultCount <= countNext;
        end
    end

endmodule

/* verilog/freeBitCounter.sv */
module freeBitCounter (
    input logic clk,
    input logic rst,
    input permutePkg::botT top,
    input permutePkg::botT inBot,
    output logic [permutePkg::FREE_COUNT_WIDTH-1:0] freeCount
);
    import permutePkg::*;

    botT uncovered;
    logic [CHUNK_POP_WIDTH-1:0] nextPop [CHUNK_COUNT];
    logic [CHUNK_POP_WIDTH-1:0] chunkPop [CHUNK_COUNT];
    logic [FREE_COUNT_WIDTH-1:0] total;

    // top bits left free by the bot
    assign uncovered = top & ~inBot;

    // per-chunk population count
    always_comb begin
        for (int c = 0; c < CHUNK_COUNT; c++) begin
            nextPop[c] = '0;
            for (int b = 0; b < CHUNK_WIDTH; b++) begin
                nextPop[c] = nextPop[c] + CHUNK_POP_WIDTH'(uncovered[c*CHUNK_WIDTH + b]);
            end
        end
    end

    // adder tree over the registered chunk counts
    always_comb begin
        total = '0;
        for (int c = 0; c < CHUNK_COUNT; c++) begin
            total = total + FREE_COUNT_WIDTH'(chunkPop[c]);
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            chunkPop <= '{default: '0};
            freeCount <= '0;
        end else begin
            chunkPop <= nextPop;
            freeCount <= total;
        end
    end

endmodule

/* verilog/subsetChecker.sv */
module subsetChecker (
    input logic clk,
    input logic rst,
    input permutePkg::botT top,
    input logic inValid,
    input logic inLast,
    input permutePkg::botT inBot,
    output logic subsetOut,
    output logic validOut,
    output logic lastOut
);
    import permutePkg::*;

    botT outside;
    logic [SUBSET_GROUPS-1:0] partialOr;
    logic [SUBSET_GROUPS-1:0] partialOrReg;
    logic validStage1;
    logic lastStage1;

    // bot bits that top does not cover
    assign outside = inBot & ~top;

    always_comb begin
        for (int g = 0; g < SUBSET_GROUPS; g++) begin
            partialOr[g] = |outside[g*(BOT_WIDTH/SUBSET_GROUPS) +: BOT_WIDTH/SUBSET_GROUPS];
        end
    end

    // stage 1 partial ORs, stage 2 final reduction
    always_ff @(posedge clk) begin
        partialOrReg <= partialOr;
        subsetOut <= ~|partialOrReg;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            validStage1 <= 1'b0;
            lastStage1 <= 1'b0;
            validOut <= 1'b0;
            lastOut <= 1'b0;
        end else begin
            validStage1 <= inValid;
            lastStage1 <= inLast;
            validOut <= validStage1;
            lastOut <= lastStage1;
        end
    end

endmodule

/* verilog/botPermuter.sv */
module botPermuter (
    input logic clk,
    input logic rst,
    input logic load,
    input permutePkg::botT botIn,
    input permutePkg::permuteMaskT maskIn,
    input logic lastIn,
    output logic idle,
    output logic outValid,
    output logic outLast,
    output permutePkg::botT outBot
);
    import permutePkg::*;

    // reorder the 16-bit chunks with A, B, C at chunk index bits 2, 1, 0
    function automatic botT permuteBot(input botT b, input logic [2:0] sel);
        logic [1:0] posX;
        logic [1:0] posY;
        logic [1:0] posZ;
        logic [2:0] src;
        botT res;
        case (sel)
            3'd5: {posX, posY, posZ} = {2'd2, 2'd1, 2'd0};
            3'd4: {posX, posY, posZ} = {2'd2, 2'd0, 2'd1};
            3'd3: {posX, posY, posZ} = {2'd1, 2'd2, 2'd0};
            3'd2: {posX, posY, posZ} = {2'd1, 2'd0, 2'd2};
            3'd1: {posX, posY, posZ} = {2'd0, 2'd2, 2'd1};
            default: {posX, posY, posZ} = {2'd0, 2'd1, 2'd2};
        endcase
        res = '0;
        for (int o = 0; o < CHUNK_COUNT; o++) begin
            src = '0;
            src[posX] = o[2];
            src[posY] = o[1];
            src[posZ] = o[0];
            res[o*CHUNK_WIDTH +: CHUNK_WIDTH] = b[src*CHUNK_WIDTH +: CHUNK_WIDTH];
        end
        return res;
    endfunction

    botT botReg;
    permuteMaskT remaining;
    logic lastReg;

    botT curBot;
    permuteMaskT curMask;
    permuteMaskT nextMask;
    logic curLast;
    logic [2:0] curSel;
    logic step;

    // a fresh load is handled in the same cycle as its first permutation
    always_comb begin
        curBot = load ? botIn : botReg;
        curMask = load ? maskIn : remaining;
        curLast = load ? lastIn : lastReg;
        curSel = '0;
        for (int k = 0; k < PERMUTE_COUNT; k++) begin
            if (curMask[k]) begin
                curSel = 3'(k);
            end
        end
        nextMask = curMask & ~(permuteMaskT'(1) << curSel);
    end

    assign step = load || (!idle && remaining != '0);

    always_ff @(posedge clk) begin
        if (rst) begin
            idle <= 1'b1;
            outValid <= 1'b0;
            outLast <= 1'b0;
            remaining <= '0;
        end else if (step) begin
            idle <= 1'b0;
            // zero mask with batch end gives a lone last marker
            outValid <= |curMask;
            outLast <= curLast && (nextMask == '0);
            remaining <= nextMask;
        end else begin
            idle <= 1'b1;
            outValid <= 1'b0;
            outLast <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            botReg <= botIn;
            lastReg <= lastIn;
        end
        if (step) begin
            outBot <= permuteBot(curBot, curSel);
        end
    end

endmodule

/* verilog/syncFifo.sv */
module syncFifo #(
    parameter type payloadT = logic [7:0],
    parameter int DEPTH_LOG2 = 4
) (
    input logic clk,
    input logic rst,
    input logic writeEnable,
    input payloadT dataIn,
    input logic readEnable,
    output payloadT dataOut,
    output logic empty,
    output logic [DEPTH_LOG2:0] usedw
);

    payloadT mem [2**DEPTH_LOG2];
    logic [DEPTH_LOG2-1:0] writePtr;
    logic [DEPTH_LOG2-1:0] readPtr;
    logic full;
    logic doWrite;
    logic doRead;

    assign empty = (usedw == '0);
    assign full = usedw[DEPTH_LOG2];

    // overflow and underflow requests are dropped
    assign doWrite = writeEnable && !full;
    assign doRead = readEnable && !empty;

    // show-ahead read of the head entry
    assign dataOut = mem[readPtr];

    always_ff @(posedge clk) begin
        if (doWrite) begin
            mem[writePtr] <= dataIn;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            writePtr <= '0;
            readPtr <= '0;
            usedw <= '0;
        end else begin
            if (doWrite) begin
                writePtr <= writePtr + 1'b1;
            end
            if (doRead) begin
                readPtr <= readPtr + 1'b1;
            end
            // fill level tracks the net change
            case ({doWrite, doRead})
                2'b10: usedw <= usedw + 1'b1;
                2'b01: usedw <= usedw - 1'b1;
                default: usedw <= usedw;
            endcase
        end
    end

endmodule

/* verilog/permutePkg.sv */
package permutePkg;

    // truth table geometry for 7 variables A..G
    localparam int BOT_WIDTH = 128;
    localparam int CHUNK_WIDTH = 16;
    localparam int CHUNK_COUNT = BOT_WIDTH / CHUNK_WIDTH;
    localparam int CHUNK_POP_WIDTH = $clog2(CHUNK_WIDTH + 1);
    localparam int SUBSET_GROUPS = 16;

    // mask bits 5..0 select ABC, ACB, BAC, BCA, CAB, CBA
    localparam int PERMUTE_COUNT = 6;

    // result widths
    localparam int FREE_COUNT_WIDTH = 8;
    localparam int COUNT_WIDTH = 10;
    localparam int SUM_WIDTH = COUNT_WIDTH + FREE_COUNT_WIDTH;

    // fifo sizing and flow control
    localparam int INPUT_FIFO_DEPTH_LOG2 = 5;
    localparam int SLOW_DOWN_THRESHOLD = 24;
    localparam int RESULTS_FIFO_DEPTH_LOG2 = 4;
    localparam int RESULTS_HEADROOM = 4;

    typedef logic [BOT_WIDTH-1:0] botT;
    typedef logic [PERMUTE_COUNT-1:0] permuteMaskT;

    typedef struct packed {
        botT bot;
        permuteMaskT mask;
        logic batchDone;
    } inputEntryT;

    typedef struct packed {
        logic [SUM_WIDTH-1:0] sum;
        logic [COUNT_WIDTH-1:0] count;
    } resultEntryT;

endpackage
